// ==== design/laneDefs.sv ====
// Widths, command and sub-op codes and stage payloads of the secondary lane execute path
// Every lane module imports what it needs from here
`default_nettype none

package laneDefs;

	localparam int valueWidth = 64;	// Operand and result width
	localparam int regIdWidth = 6;	// GPR id width
	localparam int immWidth = 33;	// Decoded immediate, sign bit on top

	typedef logic [regIdWidth-1:0] regIdT;

	localparam regIdT regZero = regIdT'(0);	// Zero register, writes dropped

	typedef enum logic [5:0] {
		cmdNop   = 6'h00,
		cmdMovIr = 6'h01,	// Immediate move
		cmdLeaMr = 6'h02,	// Address generation move
		cmdMovMr = 6'h03,	// Load, data comes from memory later
		cmdAlu3  = 6'h04,	// Three-operand ALU
		cmdUnary = 6'h05,	// Single-operand ALU on B
		cmdAluW3 = 6'h06,	// 32-bit ALU, sign-extended
		cmdMulW3 = 6'h07	// Word multiply, result in EX2
	} uCmdT;

	// Sub-op field; LEA reads only the low two bits as the index scale
	typedef logic [5:0] uIxtT;

	localparam uIxtT ixAdd = 6'h00;	// Also ALUW3 add
	localparam uIxtT ixSub = 6'h01;	// Also ALUW3 sub
	localparam uIxtT ixAnd = 6'h02;
	localparam uIxtT ixOr  = 6'h03;
	localparam uIxtT ixXor = 6'h04;
	localparam uIxtT ixNot = 6'h05;	// UNARY only
	localparam uIxtT ixNeg = 6'h06;	// UNARY only

	// Issue register payload, command kept in the top bits
	typedef struct packed {
		uCmdT uCmd;
		uIxtT uIxt;
		regIdT regIdRm;
		logic [valueWidth-1:0] regValRs;
		logic [valueWidth-1:0] regValRt;
		logic [immWidth-1:0] regValImm;
	} issueBundleT;

	// EX1/EX2 register payload, command kept in the top bits
	typedef struct packed {
		uCmdT uCmd;
		regIdT regIdRm;
		regIdT regIdRn1;
		logic [valueWidth-1:0] regValRn1;
	} ex2BundleT;

endpackage

`default_nettype wire

// ==== design/pipeStage.sv ====
// Stage register between lane stages, one packed payload per cycle
// Reset loads resetValue so the lane comes up with NOP ops and zero-register ids
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
	parameter type payloadType = logic,
	parameter payloadType resetValue = '0
) (
	input wire clock,
	input wire reset,
	input wire payloadType dataIn,
	output payloadType dataOut
);
	import laneDefs::*;

	localparam int cmdTop = $bits(payloadType) - 1;	// Command leads each bundle

	always_ff @(posedge clock) begin
		if (reset) begin
			dataOut <= resetValue;	// NOP, ids at regZero
		end else begin
			dataOut <= dataIn;	// Advance one stage
		end
	end

	// An X command here would spread through both decoders downstream
	cmdNeverUnknown: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(dataOut[cmdTop -: $bits(uCmdT)]))
		else $error("pipeStage: command field unknown after reset");

endmodule

`default_nettype wire

// ==== design/laneAlu.sv ====
// Combinational 64-bit ALU used by EX1 for ALU3, UNARY and ALUW3 ops
// Result is 0 for commands and sub-ops it does not handle
`timescale 1ns/1ps
`default_nettype none

module laneAlu (
	input wire laneDefs::uCmdT opUCmd,
	input wire laneDefs::uIxtT opUIxt,
	input wire [laneDefs::valueWidth-1:0] valA,
	input wire [laneDefs::valueWidth-1:0] valB,
	output logic [laneDefs::valueWidth-1:0] result
);
	import laneDefs::*;

	logic [31:0] wordSum;	// ALUW3 low word before extension

	always_comb begin
		wordSum = '0;
		result = '0;	// Unhandled op gives 0
		case (opUCmd)
			cmdAlu3: begin
				case (opUIxt)
					ixAdd: result = valA + valB;
					ixSub: result = valA - valB;
					ixAnd: result = valA & valB;
					ixOr: result = valA | valB;
					ixXor: result = valA ^ valB;
					default: result = '0;
				endcase
			end
			cmdUnary: begin
				case (opUIxt)
					ixNot: result = ~valB;	// A is ignored
					ixNeg: result = -valB;
					default: result = '0;
				endcase
			end
			cmdAluW3: begin
				case (opUIxt)
					ixAdd: wordSum = valA[31:0] + valB[31:0];	// Wraps at 32 bits
					ixSub: wordSum = valA[31:0] - valB[31:0];
					default: wordSum = '0;
				endcase
				result = {{(valueWidth-32){wordSum[31]}}, wordSum};	// Sign-extend
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/mulwUnit.sv ====
// Signed 32x32 word multiplier, started by EX1 and read by EX2 one cycle later
// Product holds its value until the next start
`timescale 1ns/1ps
`default_nettype none

module mulwUnit (
	input wire clock,
	input wire reset,
	input wire start,
	input wire [laneDefs::valueWidth-1:0] valA,
	input wire [laneDefs::valueWidth-1:0] valB,
	output logic [laneDefs::valueWidth-1:0] product
);
	import laneDefs::*;

	logic signed [valueWidth-1:0] wordProduct;	// Full 64-bit signed product

	assign wordProduct = valueWidth'($signed(valA[31:0]))
		* valueWidth'($signed(valB[31:0]));	// Low words, sign-extended first

	always_ff @(posedge clock) begin
		if (reset) begin
			product <= '0;
		end else if (start) begin
			product <= wordProduct;	// Lines up with the op entering EX2
		end
	end

	// An X start would leave EX2 reading a product of unknown age
	startKnown: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(start))
		else $error("mulwUnit: start unknown");

endmodule

`default_nettype wire

// ==== design/ex1Stage.sv ====
// EX1 of the lane, decodes the op and picks the EX1 destination id and value
// Ops that finish in EX2 leave the zero register here
`timescale 1ns/1ps
`default_nettype none

module ex1Stage (
	input wire laneDefs::uCmdT opUCmd,
	input wire laneDefs::uIxtT opUIxt,
	input wire laneDefs::regIdT regIdRm,
	input wire [laneDefs::valueWidth-1:0] regValRs,
	input wire [laneDefs::valueWidth-1:0] regValRt,
	input wire [laneDefs::immWidth-1:0] regValImm,
	output laneDefs::regIdT regIdRn1,
	output logic [laneDefs::valueWidth-1:0] regValRn1
);
	import laneDefs::*;

	logic [valueWidth-1:0] aluResult;

	laneAlu alu (
		.opUCmd(opUCmd),
		.opUIxt(opUIxt),
		.valA(regValRs),
		.valB(regValRt),
		.result(aluResult)
	);

	always_comb begin
		regIdRn1 = regZero;	// No write by default
		regValRn1 = '0;
		case (opUCmd)
			cmdMovIr: begin
				regIdRn1 = regIdRm;
				regValRn1 = {{(valueWidth-immWidth){regValImm[immWidth-1]}}, regValImm};
			end
			cmdLeaMr: begin
				regIdRn1 = regIdRm;
				regValRn1 = regValRs + (regValRt << opUIxt[1:0]);	// Base plus scaled index
			end
			cmdAlu3, cmdUnary, cmdAluW3: begin
				regIdRn1 = regIdRm;
				regValRn1 = aluResult;
			end
			default: begin
				// NOP, load and word multiply write nothing in EX1
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/ex2Stage.sv ====
// EX2 of the lane, forwards the EX1 destination or replaces it with a late result
// Also applies the branch flush and raises the load-held flag
`timescale 1ns/1ps
`default_nettype none

module ex2Stage (
	input wire laneDefs::uCmdT opUCmd,
	input wire laneDefs::regIdT regIdRm,
	input wire laneDefs::regIdT regIdRn1,
	input wire [laneDefs::valueWidth-1:0] regValRn1,
	input wire [laneDefs::valueWidth-1:0] regValMulwRes,
	input wire opBraFlush,
	output laneDefs::regIdT regIdRn2,
	output logic [laneDefs::valueWidth-1:0] regValRn2,
	output logic regHeld
);
	import laneDefs::*;

	uCmdT liveCmd;	// Command after the flush

	always_comb begin
		liveCmd = opBraFlush ? cmdNop : opUCmd;	// Flushed op decodes as NOP
		regIdRn2 = regIdRn1;	// Forward EX1 by default
		regValRn2 = regValRn1;
		regHeld = 1'b0;
		case (liveCmd)
			cmdMulW3: begin
				regIdRn2 = regIdRm;
				regValRn2 = regValMulwRes;	// Product registered during EX1
			end
			cmdMovMr: begin
				regHeld = 1'b1;	// Value arrives from memory
			end
			default: begin
				// Everything else finished in EX1
			end
		endcase
		if (opBraFlush) begin
			regIdRn2 = regZero;	// Kill the write
		end
	end

	// X commands are caught at the EX1/EX2 register, this one checks the code range
	always_comb begin
		if (!$isunknown({opBraFlush, opUCmd}) && !opBraFlush) begin
			cmdKnown: assert (opUCmd inside {cmdNop, cmdMovIr, cmdLeaMr, cmdMovMr,
				cmdAlu3, cmdUnary, cmdAluW3, cmdMulW3})
				else $error("ex2Stage: unhandled command %h", opUCmd);
		end
	end

endmodule

`default_nettype wire

// ==== design/laneExecute.sv ====
// Execute path of the secondary issue lane, issue register, EX1, multiplier and EX2
// One op per cycle in, EX2 destination and load-held flag out three edges later
`timescale 1ns/1ps
`default_nettype none

module laneExecute (
	input wire clock,
	input wire reset,
	input wire laneDefs::uCmdT opUCmd,
	input wire laneDefs::uIxtT opUIxt,
	input wire laneDefs::regIdT regIdRm,
	input wire [laneDefs::valueWidth-1:0] regValRs,
	input wire [laneDefs::valueWidth-1:0] regValRt,
	input wire [laneDefs::immWidth-1:0] regValImm,
	input wire opBraFlush,
	output laneDefs::regIdT regIdRn2,
	output logic [laneDefs::valueWidth-1:0] regValRn2,
	output logic regHeld
);
	import laneDefs::*;

	localparam issueBundleT issueReset = '{
		uCmd: cmdNop,
		uIxt: '0,
		regIdRm: regZero,
		regValRs: '0,
		regValRt: '0,
		regValImm: '0
	};

	localparam ex2BundleT ex2Reset = '{
		uCmd: cmdNop,
		regIdRm: regZero,
		regIdRn1: regZero,
		regValRn1: '0
	};

	issueBundleT issueIn;
	issueBundleT issueOut;	// Op in EX1
	ex2BundleT ex2In;
	ex2BundleT ex2Out;	// Op in EX2
	regIdT regIdRn1;
	logic [valueWidth-1:0] regValRn1;
	logic [valueWidth-1:0] mulwProduct;
	logic mulwStart;

	assign issueIn = '{
		uCmd: opUCmd,
		uIxt: opUIxt,
		regIdRm: regIdRm,
		regValRs: regValRs,
		regValRt: regValRt,
		regValImm: regValImm
	};

	pipeStage #(
		.payloadType(issueBundleT),
		.resetValue(issueReset)
	) issueStage (
		.clock(clock),
		.reset(reset),
		.dataIn(issueIn),
		.dataOut(issueOut)
	);

	ex1Stage ex1 (
		.opUCmd(issueOut.uCmd),
		.opUIxt(issueOut.uIxt),
		.regIdRm(issueOut.regIdRm),
		.regValRs(issueOut.regValRs),
		.regValRt(issueOut.regValRt),
		.regValImm(issueOut.regValImm),
		.regIdRn1(regIdRn1),
		.regValRn1(regValRn1)
	);

	assign mulwStart = (issueOut.uCmd == cmdMulW3);	// Multiply begins in EX1

	mulwUnit mulw (
		.clock(clock),
		.reset(reset),
		.start(mulwStart),
		.valA(issueOut.regValRs),
		.valB(issueOut.regValRt),
		.product(mulwProduct)
	);

	assign ex2In = '{
		uCmd: issueOut.uCmd,
		regIdRm: issueOut.regIdRm,
		regIdRn1: regIdRn1,
		regValRn1: regValRn1
	};

	pipeStage #(
		.payloadType(ex2BundleT),
		.resetValue(ex2Reset)
	) ex2Reg (
		.clock(clock),
		.reset(reset),
		.dataIn(ex2In),
		.dataOut(ex2Out)
	);

	ex2Stage ex2 (
		.opUCmd(ex2Out.uCmd),
		.regIdRm(ex2Out.regIdRm),
		.regIdRn1(ex2Out.regIdRn1),
		.regValRn1(ex2Out.regValRn1),
		.regValMulwRes(mulwProduct),	// Same cycle as its op
		.opBraFlush(opBraFlush),
		.regIdRn2(regIdRn2),
		.regValRn2(regValRn2),
		.regHeld(regHeld)
	);

endmodule

`default_nettype wire

// ==== tb/laneVectors.svh ====
// Stimulus table for the lane testbench, one op per row, applied in order
// addRow columns are name, command, sub-op, Rm, Rs, Rt, immediate, flush, random operands
`ifndef LANE_VECTORS_SVH
`define LANE_VECTORS_SVH

typedef struct packed {
	uCmdT cmd;
	uIxtT ixt;
	regIdT rm;
	logic [valueWidth-1:0] rs;
	logic [valueWidth-1:0] rt;
	logic [immWidth-1:0] imm;
	logic flush;	// Kill this op in EX2
	logic rnd;	// Rs and Rt from $urandom
} vecRowT;

vecRowT rows[$];
string rowNames[$];

task automatic addRow(input string name, input uCmdT cmd, input uIxtT ixt, input regIdT rm,
	input logic [valueWidth-1:0] rs, input logic [valueWidth-1:0] rt,
	input logic [immWidth-1:0] imm, input logic flush, input logic rnd);
	rows.push_back('{cmd, ixt, rm, rs, rt, imm, flush, rnd});
	rowNames.push_back(name);
endtask

task automatic buildVectors();
	addRow("movIrPos", cmdMovIr, ixAdd, 6'd1, 64'h0, 64'h0, 33'h0_1234_5678, 1'b0, 1'b0);
	addRow("movIrNeg", cmdMovIr, ixAdd, 6'd2, 64'h0, 64'h0, 33'h1_ffff_fff0, 1'b0, 1'b0);
	addRow("leaScale0", cmdLeaMr, 6'h00, 6'd3, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("leaScale1", cmdLeaMr, 6'h01, 6'd4, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("leaScale2", cmdLeaMr, 6'h02, 6'd5, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("leaScale3", cmdLeaMr, 6'h03, 6'd6, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("leaHighBits", cmdLeaMr, 6'h3d, 6'd7, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);	// Scale 1
	addRow("alu3Add", cmdAlu3, ixAdd, 6'd8, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("alu3Sub", cmdAlu3, ixSub, 6'd9, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("alu3And", cmdAlu3, ixAnd, 6'd10, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("alu3Or", cmdAlu3, ixOr, 6'd11, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("alu3Xor", cmdAlu3, ixXor, 6'd12, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("alu3BadIxt", cmdAlu3, 6'h3f, 6'd13, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("unaryNot", cmdUnary, ixNot, 6'd14, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("unaryNeg", cmdUnary, ixNeg, 6'd15, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("aluW3Wrap", cmdAluW3, ixAdd, 6'd16, 64'hffff_ffff_7fff_ffff, 64'h1, 33'h0, 1'b0, 1'b0);
	addRow("aluW3Sub", cmdAluW3, ixSub, 6'd17, 64'h5, 64'h7, 33'h0, 1'b0, 1'b0);
	addRow("mulwNeg", cmdMulW3, ixAdd, 6'd18, 64'hffff_ffff_ffff_fffd, 64'h7, 33'h0, 1'b0, 1'b0);
	addRow("mulwRndA", cmdMulW3, ixAdd, 6'd19, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("mulwRndB", cmdMulW3, ixAdd, 6'd20, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("loadMr", cmdMovMr, ixAdd, 6'd21, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("nop", cmdNop, ixAdd, 6'd22, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("aluFlushed", cmdAlu3, ixAdd, 6'd23, 64'h0, 64'h0, 33'h0, 1'b1, 1'b1);
	addRow("mulwFlushed", cmdMulW3, ixAdd, 6'd24, 64'h0, 64'h0, 33'h0, 1'b1, 1'b1);
	addRow("mulwAfterFlush", cmdMulW3, ixAdd, 6'd25, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
	addRow("loadFlushed", cmdMovMr, ixAdd, 6'd26, 64'h0, 64'h0, 33'h0, 1'b1, 1'b1);
	addRow("aluAfterFlush", cmdAlu3, ixXor, 6'd27, 64'h0, 64'h0, 33'h0, 1'b0, 1'b1);
endtask

`endif

// ==== tb/laneExecuteTb.sv ====
// Table-driven testbench for the lane execute path, checks EX2 outputs three edges after issue
// Rows come from laneVectors.svh, flush of each row is driven when that op sits in EX2
`timescale 1ns/1ps
`default_nettype none

module laneExecuteTb;
	import laneDefs::*;

	localparam int clockPeriod = 10;
	localparam int resetCycles = 10;

	logic clock;
	logic reset;
	uCmdT opUCmd;
	uIxtT opUIxt;
	regIdT regIdRm;
	logic [valueWidth-1:0] regValRs;
	logic [valueWidth-1:0] regValRt;
	logic [immWidth-1:0] regValImm;
	logic opBraFlush;
	regIdT regIdRn2;
	logic [valueWidth-1:0] regValRn2;
	logic regHeld;
	logic vectorsReady = 1'b0;

	`include "laneVectors.svh"

	// Delay line of ops still in flight
	regIdT idQ[$];
	logic [valueWidth-1:0] valQ[$];
	logic heldQ[$];
	logic flushQ[$];
	string nameQ[$];

	laneExecute dut (
		.clock(clock),
		.reset(reset),
		.opUCmd(opUCmd),
		.opUIxt(opUIxt),
		.regIdRm(regIdRm),
		.regValRs(regValRs),
		.regValRt(regValRt),
		.regValImm(regValImm),
		.opBraFlush(opBraFlush),
		.regIdRn2(regIdRn2),
		.regValRn2(regValRn2),
		.regHeld(regHeld)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	task automatic stopOnError();
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Lane rules, flush applied by the caller
	function automatic void expectedResult(input vecRowT r, output regIdT id,
		output logic [valueWidth-1:0] val, output logic held);
		logic [31:0] word;
		longint sa;
		longint sb;
		id = r.rm;
		val = '0;
		held = 1'b0;
		word = '0;
		case (r.cmd)
			cmdMovIr: val = longint'($signed(r.imm));
			cmdLeaMr: val = r.rs + r.rt * (64'd1 << r.ixt[1:0]);
			cmdAlu3: begin
				if (r.ixt == ixAdd) val = r.rs + r.rt;
				else if (r.ixt == ixSub) val = r.rs - r.rt;
				else if (r.ixt == ixAnd) val = r.rs & r.rt;
				else if (r.ixt == ixOr) val = r.rs | r.rt;
				else if (r.ixt == ixXor) val = r.rs ^ r.rt;
			end
			cmdUnary: begin
				if (r.ixt == ixNot) val = ~r.rt;
				else if (r.ixt == ixNeg) val = 64'd0 - r.rt;
			end
			cmdAluW3: begin
				if (r.ixt == ixAdd) word = r.rs[31:0] + r.rt[31:0];	// 32-bit wrap
				else if (r.ixt == ixSub) word = r.rs[31:0] - r.rt[31:0];
				val = longint'($signed(word));
			end
			cmdMulW3: begin
				sa = longint'($signed(r.rs[31:0]));
				sb = longint'($signed(r.rt[31:0]));
				val = sa * sb;
			end
			cmdMovMr: begin
				id = regZero;	// Value comes from memory
				held = 1'b1;
			end
			default: id = regZero;	// NOP
		endcase
	endfunction

	task automatic driveRow(input vecRowT r);
		opUCmd = r.cmd;
		opUIxt = r.ixt;
		regIdRm = r.rm;
		regValRs = r.rs;
		regValRt = r.rt;
		regValImm = r.imm;
	endtask

	task automatic checkOutputs(input string name, input regIdT eId,
		input logic [valueWidth-1:0] eVal, input logic eHeld, input logic checkValue);
		assert (regIdRn2 === eId) else begin
			$display("[ERROR] %s regIdRn2 expected %0d actual %0d", name, eId, regIdRn2);
			stopOnError();
		end
		assert (regHeld === eHeld) else begin
			$display("[ERROR] %s regHeld expected %0b actual %0b", name, eHeld, regHeld);
			stopOnError();
		end
		if (checkValue) begin
			assert (regValRn2 === eVal) else begin
				$display("[ERROR] %s regValRn2 expected %h actual %h", name, eVal, regValRn2);
				stopOnError();
			end
		end
	endtask

	initial begin
		vecRowT row;
		regIdT eId;
		logic [valueWidth-1:0] eVal;
		logic eHeld;
		void'($urandom(44));	// Seed once
		buildVectors();
		vectorsReady = 1'b1;
		driveRow('0);	// NOP on all issue inputs
		opBraFlush = 1'b0;
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		#1 reset = 1'b0;
		checkOutputs("afterReset", regZero, '0, 1'b0, 1'b0);
		for (int i = 0; i < rows.size() + 2; i++) begin
			@(posedge clock);
			#1;
			if (i < rows.size()) begin
				row = rows[i];
				if (row.rnd) begin
					row.rs = {$urandom(), $urandom()};
					row.rt = {$urandom(), $urandom()};
				end
				driveRow(row);
				expectedResult(row, eId, eVal, eHeld);
				idQ.push_back(eId);
				valQ.push_back(eVal);
				heldQ.push_back(eHeld);
				flushQ.push_back(row.flush);
				nameQ.push_back(rowNames[i]);
			end else begin
				driveRow('0);	// Drain with NOPs
			end
			opBraFlush = (i >= 2) ? flushQ[0] : 1'b0;	// Op issued two rows ago is in EX2
			#(clockPeriod - 2);	// Sample just before the next edge
			if (i < 2) begin
				checkOutputs("startup", regZero, '0, 1'b0, 1'b0);
			end else begin
				if (flushQ[0]) checkOutputs(nameQ[0], regZero, '0, 1'b0, 1'b0);
				else checkOutputs(nameQ[0], idQ[0], valQ[0], heldQ[0], 1'b1);
				void'(idQ.pop_front());
				void'(valQ.pop_front());
				void'(heldQ.pop_front());
				void'(flushQ.pop_front());
				void'(nameQ.pop_front());
			end
		end
		$display("Simulation completed successfully");
		$finish;
	end

	// Watchdog sized from reset, table length and margin
	initial begin
		wait (vectorsReady);
		#((resetCycles + rows.size() + 20) * clockPeriod);
		$display("Timeout: the vector table did not finish in time");
		stopOnError();
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+tb
design/laneDefs.sv
design/pipeStage.sv
design/laneAlu.sv
design/mulwUnit.sv
design/ex1Stage.sv
design/ex2Stage.sv
design/laneExecute.sv
tb/laneExecuteTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module laneExecuteTb -o laneExecuteSim
output=$(./obj_dir/laneExecuteSim 2>&1 || true)
echo "$output"
if echo "$output" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1
